// ==== flist.f ====
+incdir+src
src/axil_pkg.sv
src/split_pkg.sv
src/rsp_queue_if.sv
src/skid_buffer.sv
src/rsp_queue.sv
src/write_splitter.sv
src/read_splitter.sv
src/axil_single_split.sv
testbench/tb_axil_single_split.sv

// ==== testbench/tb_axil_single_split.sv ====
/* Splitter testbench */

`timescale 1ns/1ps
`include "axil_split_macros.svh"

module tb_axil_single_split
	import axil_pkg::*;
	import split_pkg::*;
;

	localparam int NS       = `SPLIT_NS;
	localparam int DW       = `SPLIT_DW;
	localparam int AW       = `SPLIT_AW;
	localparam int TIMEOUT  = 1000;
	localparam int MAX_ROWS = 64;
	// Peripheral that always answers with SLVERR
	localparam int SLV_IDX  = 5;
	localparam logic OP_WR  = 1'b0;
	localparam logic OP_RD  = 1'b1;

	logic                 S_AXI_ACLK = 1'b0;
	logic                 S_AXI_ARESETN;
	logic                 i_s_awvalid;
	logic                 o_s_awready;
	logic [AW-1:0]        i_s_awaddr;
	logic [PROT_W-1:0]    i_s_awprot;
	logic                 i_s_wvalid;
	logic                 o_s_wready;
	logic [DW-1:0]        i_s_wdata;
	logic [STRB_W-1:0]    i_s_wstrb;
	logic                 o_s_bvalid;
	logic                 i_s_bready;
	logic [1:0]           o_s_bresp;
	logic                 i_s_arvalid;
	logic                 o_s_arready;
	logic [AW-1:0]        i_s_araddr;
	logic [PROT_W-1:0]    i_s_arprot;
	logic                 o_s_rvalid;
	logic                 i_s_rready;
	logic [DW-1:0]        o_s_rdata;
	logic [1:0]           o_s_rresp;
	logic [NS-1:0]        o_m_awvalid;
	logic [PROT_W-1:0]    o_m_awprot;
	logic [DW-1:0]        o_m_wdata;
	logic [STRB_W-1:0]    o_m_wstrb;
	logic [NS*2-1:0]      i_m_bresp;
	logic [NS-1:0]        o_m_arvalid;
	logic [PROT_W-1:0]    o_m_arprot;
	logic [NS*DW-1:0]     i_m_rdata;
	logic [NS*2-1:0]      i_m_rresp;

	// Peripheral registers and their registered answers
	logic [DW-1:0]        regs    [NS];
	logic [DW-1:0]        rdata_q [NS];
	logic [1:0]           bresp_q [NS];
	logic [1:0]           rresp_q [NS];

	// Stimulus table, one row per operation
	logic                 row_op    [MAX_ROWS];
	logic [IDX_W-1:0]     row_idx   [MAX_ROWS];
	logic [DW-1:0]        row_data  [MAX_ROWS];
	logic [STRB_W-1:0]    row_strb  [MAX_ROWS];
	logic [1:0]           row_resp  [MAX_ROWS];
	logic [DW-1:0]        row_rdata [MAX_ROWS];
	int                   n_rows;
	int                   burst_start;

	// Expected responses in issue order
	logic [1:0]           exp_b [$];
	logic [DW+1:0]        exp_r [$];
	logic                 running;
	logic                 stall_hard;
	logic                 saw_aw_throttle;
	logic                 saw_ar_throttle;
	logic [31:0]          lfsr;

	always #2 S_AXI_ACLK = ~S_AXI_ACLK;

	axil_single_split u_dut (.*);

	////////////////////////////////////////////////////////////////////////////
	// Peripheral models
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		for (int p = 0; p < NS; p++)
		begin
			if (!S_AXI_ARESETN)
			begin
				regs[p]    <= '0;
				rdata_q[p] <= '0;
				bresp_q[p] <= RESP_OKAY;
				rresp_q[p] <= RESP_OKAY;
			end
			else
			begin
				// Byte lanes merge under the write strobes
				if (o_m_awvalid[p])
				begin
					for (int b = 0; b < STRB_W; b++)
						if (o_m_wstrb[b])
							regs[p][8*b +: 8] <= o_m_wdata[8*b +: 8];
					bresp_q[p] <= (p == SLV_IDX) ? RESP_SLVERR : RESP_OKAY;
				end
				if (o_m_arvalid[p])
				begin
					rdata_q[p] <= regs[p];
					rresp_q[p] <= (p == SLV_IDX) ? RESP_SLVERR : RESP_OKAY;
				end
			end
		end
	end

	// Zero while in reset so the DUT never sees X
	always_comb
	begin
		for (int p = 0; p < NS; p++)
		begin
			i_m_bresp[2*p +: 2]  = S_AXI_ARESETN ? bresp_q[p] : 2'b00;
			i_m_rresp[2*p +: 2]  = S_AXI_ARESETN ? rresp_q[p] : 2'b00;
			i_m_rdata[DW*p +: DW] = S_AXI_ARESETN ? rdata_q[p] : '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reporting and random bits
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [DW-1:0] exp,
		input logic [DW-1:0] got);
		$display("error at %0t: %s expected %h actual %h", $time, name, exp, got);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// Galois step, one call per bit taken
	function automatic logic take_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	// Ready for half the cycles, or one in eight during the burst
	function automatic logic ready_bit();
		logic b;
		int   n;
		b = 1'b1;
		n = stall_hard ? 3 : 1;
		for (int k = 0; k < n; k++)
			if (!take_bit())
				b = 1'b0;
		return b;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Table and bus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic add_row(input logic op, input int idx, input logic [DW-1:0] data,
		input logic [STRB_W-1:0] strb, input logic [1:0] resp, input logic [DW-1:0] rdata);
		row_op[n_rows]    = op;
		row_idx[n_rows]   = IDX_W'(idx);
		row_data[n_rows]  = data;
		row_strb[n_rows]  = strb;
		row_resp[n_rows]  = resp;
		row_rdata[n_rows] = rdata;
		n_rows++;
	endtask

	task automatic build_table();
		logic [DW-1:0] d;
		logic [1:0]    rsp;
		n_rows = 0;
		// Full strobes then readback
		add_row(OP_WR, 0,  32'h0123_4567, 4'hf, RESP_OKAY, '0);
		add_row(OP_WR, 3,  32'h1234_5678, 4'hf, RESP_OKAY, '0);
		add_row(OP_WR, 11, 32'hcafe_f00d, 4'hf, RESP_OKAY, '0);
		add_row(OP_WR, 7,  32'h7777_0007, 4'hf, RESP_OKAY, '0);
		add_row(OP_RD, 0,  '0, '0, RESP_OKAY, 32'h0123_4567);
		add_row(OP_RD, 3,  '0, '0, RESP_OKAY, 32'h1234_5678);
		add_row(OP_RD, 11, '0, '0, RESP_OKAY, 32'hcafe_f00d);
		add_row(OP_RD, 7,  '0, '0, RESP_OKAY, 32'h7777_0007);
		// Partial strobes merge into the old value
		add_row(OP_WR, 3,  32'haabb_ccdd, 4'b0101, RESP_OKAY, '0);
		add_row(OP_WR, 11, 32'hff00_0000, 4'b1000, RESP_OKAY, '0);
		add_row(OP_WR, 0,  32'h0000_9900, 4'b0010, RESP_OKAY, '0);
		add_row(OP_RD, 3,  '0, '0, RESP_OKAY, 32'h12bb_56dd);
		add_row(OP_RD, 11, '0, '0, RESP_OKAY, 32'hfffe_f00d);
		add_row(OP_RD, 0,  '0, '0, RESP_OKAY, 32'h0123_9967);
		// Error responses
		add_row(OP_WR, 5,  32'h5555_aaaa, 4'hf, RESP_SLVERR, '0);
		add_row(OP_RD, 5,  '0, '0, RESP_SLVERR, 32'h5555_aaaa);
		add_row(OP_WR, 12, 32'hdead_beef, 4'hf, RESP_DECERR, '0);
		add_row(OP_WR, 15, 32'hdead_beef, 4'hf, RESP_DECERR, '0);
		add_row(OP_RD, 13, '0, '0, RESP_DECERR, '0);
		add_row(OP_RD, 15, '0, '0, RESP_DECERR, '0);
		add_row(OP_RD, 7,  '0, '0, RESP_OKAY, 32'h7777_0007);
		// Back-to-back burst over every index, beyond the queue depth
		burst_start = n_rows;
		for (int k = 0; k < 16; k++)
		begin
			d   = 32'h5a00_0000 + k * 32'h0001_0203;
			rsp = (k >= NS) ? RESP_DECERR : ((k == SLV_IDX) ? RESP_SLVERR : RESP_OKAY);
			add_row(OP_WR, k, d, 4'hf, rsp, '0);
		end
		for (int k = 0; k < 16; k++)
		begin
			d   = (k >= NS) ? '0 : 32'h5a00_0000 + k * 32'h0001_0203;
			rsp = (k >= NS) ? RESP_DECERR : ((k == SLV_IDX) ? RESP_SLVERR : RESP_OKAY);
			add_row(OP_RD, k, '0, '0, rsp, d);
		end
	endtask

	// AW and W driven together, W strobe checked in its transfer cycle
	task automatic write_op(input logic [IDX_W-1:0] idx, input logic [DW-1:0] data,
		input logic [STRB_W-1:0] strb, input logic [1:0] resp, input logic [PROT_W-1:0] prot);
		logic          aw_hs;
		logic          w_hs;
		logic          w_done;
		logic [NS-1:0] exp_sel;
		int            n;
		exp_sel     = (idx < NS) ? (NS'(1) << idx) : '0;
		w_done      = 1'b0;
		n           = 0;
		i_s_awvalid = 1'b1;
		i_s_awaddr  = AW'(idx) << ADDR_LSBS;
		i_s_awprot  = prot;
		i_s_wvalid  = 1'b1;
		i_s_wdata   = data;
		i_s_wstrb   = strb;
		while (!w_done)
		begin
			@(negedge S_AXI_ACLK);
			aw_hs = i_s_awvalid && o_s_awready;
			w_hs  = i_s_wvalid && o_s_wready;
			if (w_hs)
			begin
				assert (o_m_awvalid == exp_sel)
				else value_error("o_m_awvalid", exp_sel, o_m_awvalid);
				assert (o_m_awprot == prot)
				else value_error("o_m_awprot", prot, o_m_awprot);
				exp_b.push_back(resp);
			end
			@(posedge S_AXI_ACLK);
			#1;
			if (aw_hs)
				i_s_awvalid = 1'b0;
			if (w_hs)
			begin
				i_s_wvalid = 1'b0;
				w_done     = 1'b1;
			end
			n++;
			if (n > TIMEOUT)
				abort_run("write handshake did not complete in time");
		end
	endtask

	// Read strobe appears one cycle after the AR transfer
	task automatic read_op(input logic [IDX_W-1:0] idx, input logic [DW-1:0] exp_data,
		input logic [1:0] resp, input logic [PROT_W-1:0] prot);
		logic          hs;
		logic [NS-1:0] exp_sel;
		int            n;
		exp_sel     = (idx < NS) ? (NS'(1) << idx) : '0;
		hs          = 1'b0;
		n           = 0;
		i_s_arvalid = 1'b1;
		i_s_araddr  = AW'(idx) << ADDR_LSBS;
		i_s_arprot  = prot;
		while (!hs)
		begin
			@(negedge S_AXI_ACLK);
			hs = o_s_arready;
			if (hs)
				exp_r.push_back({exp_data, resp});
			@(posedge S_AXI_ACLK);
			#1;
			n++;
			if (n > TIMEOUT)
				abort_run("read address handshake did not complete in time");
		end
		i_s_arvalid = 1'b0;
		@(negedge S_AXI_ACLK);
		assert (o_m_arvalid == exp_sel)
		else value_error("o_m_arvalid", exp_sel, o_m_arvalid);
		assert (o_m_arprot == prot)
		else value_error("o_m_arprot", prot, o_m_arprot);
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Response side, LFSR stalls and in-order checks
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : respond
		logic [1:0]    b_exp;
		logic [DW+1:0] r_exp;
		forever
		begin
			@(posedge S_AXI_ACLK);
			#1;
			if (running)
			begin
				i_s_bready = ready_bit();
				i_s_rready = ready_bit();
			end
			@(negedge S_AXI_ACLK);
			if (running && !o_s_awready)
				saw_aw_throttle = 1'b1;
			if (running && !o_s_arready)
				saw_ar_throttle = 1'b1;
			if (o_s_bvalid && i_s_bready)
			begin
				assert (exp_b.size() != 0)
				else abort_run("write response arrived with none outstanding");
				b_exp = exp_b.pop_front();
				assert (o_s_bresp == b_exp)
				else value_error("o_s_bresp", b_exp, o_s_bresp);
			end
			if (o_s_rvalid && i_s_rready)
			begin
				assert (exp_r.size() != 0)
				else abort_run("read response arrived with none outstanding");
				r_exp = exp_r.pop_front();
				assert (o_s_rdata == r_exp[DW+1:2])
				else value_error("o_s_rdata", r_exp[DW+1:2], o_s_rdata);
				assert (o_s_rresp == r_exp[1:0])
				else value_error("o_s_rresp", r_exp[1:0], o_s_rresp);
			end
		end
	end

	initial
	begin : main
		int n;
		S_AXI_ARESETN   = 1'b0;
		i_s_awvalid     = 1'b0;
		i_s_awaddr      = '0;
		i_s_awprot      = '0;
		i_s_wvalid      = 1'b0;
		i_s_wdata       = '0;
		i_s_wstrb       = '0;
		i_s_bready      = 1'b0;
		i_s_arvalid     = 1'b0;
		i_s_araddr      = '0;
		i_s_arprot      = '0;
		i_s_rready      = 1'b0;
		lfsr            = 32'hf84c_4c38;
		running         = 1'b0;
		stall_hard      = 1'b0;
		saw_aw_throttle = 1'b0;
		saw_ar_throttle = 1'b0;
		build_table();

		repeat (4) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		// Idle state out of reset
		@(negedge S_AXI_ACLK);
		assert (!o_s_bvalid) else value_error("o_s_bvalid", 0, o_s_bvalid);
		assert (!o_s_rvalid) else value_error("o_s_rvalid", 0, o_s_rvalid);
		assert (!o_s_wready) else value_error("o_s_wready", 0, o_s_wready);
		assert (o_m_awvalid == '0) else value_error("o_m_awvalid", 0, o_m_awvalid);
		assert (o_m_arvalid == '0) else value_error("o_m_arvalid", 0, o_m_arvalid);
		assert (o_s_awready) else value_error("o_s_awready", 1, o_s_awready);
		assert (o_s_arready) else value_error("o_s_arready", 1, o_s_arready);
		running = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;

		for (int i = 0; i < n_rows; i++)
		begin
			if (i == burst_start)
				stall_hard = 1'b1;
			if (row_op[i] == OP_WR)
				write_op(row_idx[i], row_data[i], row_strb[i], row_resp[i], PROT_W'(i));
			else
				read_op(row_idx[i], row_rdata[i], row_resp[i], PROT_W'(i));
		end

		// Drain every outstanding response
		n = 0;
		while (exp_b.size() != 0 || exp_r.size() != 0)
		begin
			@(posedge S_AXI_ACLK);
			n++;
			if (n > TIMEOUT)
				abort_run("responses still outstanding after the last operation");
		end
		// Quiet period to catch any extra response
		repeat (16) @(posedge S_AXI_ACLK);

		assert (saw_aw_throttle)
		else abort_run("write address back-pressure never seen");
		assert (saw_ar_throttle)
		else abort_run("read path never reached its credit limit");
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== src/axil_single_split.sv ====
/* AXI4-Lite single-register splitter */

`timescale 1ns/1ps
`include "axil_split_macros.svh"

module axil_single_split
	import axil_pkg::*;
	import split_pkg::*;
(
	input  logic                           S_AXI_ACLK,
	input  logic                           S_AXI_ARESETN,
	// Upstream slave port
	input  logic                           i_s_awvalid,
	output logic                           o_s_awready,
	input  logic [`SPLIT_AW-1:0]           i_s_awaddr,
	input  logic [PROT_W-1:0]              i_s_awprot,
	input  logic                           i_s_wvalid,
	output logic                           o_s_wready,
	input  logic [`SPLIT_DW-1:0]           i_s_wdata,
	input  logic [STRB_W-1:0]              i_s_wstrb,
	output logic                           o_s_bvalid,
	input  logic                           i_s_bready,
	output logic [1:0]                     o_s_bresp,
	input  logic                           i_s_arvalid,
	output logic                           o_s_arready,
	input  logic [`SPLIT_AW-1:0]           i_s_araddr,
	input  logic [PROT_W-1:0]              i_s_arprot,
	output logic                           o_s_rvalid,
	input  logic                           i_s_rready,
	output logic [`SPLIT_DW-1:0]           o_s_rdata,
	output logic [1:0]                     o_s_rresp,
	// Peripheral side
	output logic [`SPLIT_NS-1:0]           o_m_awvalid,
	output logic [PROT_W-1:0]              o_m_awprot,
	output logic [`SPLIT_DW-1:0]           o_m_wdata,
	output logic [STRB_W-1:0]              o_m_wstrb,
	input  logic [`SPLIT_NS*2-1:0]         i_m_bresp,
	output logic [`SPLIT_NS-1:0]           o_m_arvalid,
	output logic [PROT_W-1:0]              o_m_arprot,
	input  logic [`SPLIT_NS*`SPLIT_DW-1:0] i_m_rdata,
	input  logic [`SPLIT_NS*2-1:0]         i_m_rresp
);

	// B queue holds BRESP, R queue holds {RDATA, RRESP}
	rsp_queue_if #(.W(2))             u_bq_if (.S_AXI_ACLK, .S_AXI_ARESETN);
	rsp_queue_if #(.W(`SPLIT_DW + 2)) u_rq_if (.S_AXI_ACLK, .S_AXI_ARESETN);

	////////////////////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////////////////////

	write_splitter u_wr (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid    (i_s_awvalid),
		.o_awready    (o_s_awready),
		.i_awaddr     (i_s_awaddr),
		.i_awprot     (i_s_awprot),
		.i_wvalid     (i_s_wvalid),
		.o_wready     (o_s_wready),
		.o_m_awvalid  (o_m_awvalid),
		.o_m_awprot   (o_m_awprot),
		.i_m_bresp    (i_m_bresp),
		.rq           (u_bq_if.producer)
	);

	rsp_queue #(.LGFLEN(`SPLIT_LGFLEN)) u_bq (.q(u_bq_if.queue));

	// Data and strobes go to every peripheral, AWVALID picks one
	assign o_m_wdata = i_s_wdata;
	assign o_m_wstrb = i_s_wstrb;

	// Pop formed here once, also returns a write credit
	assign u_bq_if.pop = i_s_bready && !u_bq_if.empty;
	assign o_s_bvalid  = !u_bq_if.empty;
	assign o_s_bresp   = u_bq_if.pop_data;

	////////////////////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////////////////////

	read_splitter u_rd (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_arvalid    (i_s_arvalid),
		.o_arready    (o_s_arready),
		.i_araddr     (i_s_araddr),
		.i_arprot     (i_s_arprot),
		.o_m_arvalid  (o_m_arvalid),
		.o_m_arprot   (o_m_arprot),
		.i_m_rdata    (i_m_rdata),
		.i_m_rresp    (i_m_rresp),
		.rq           (u_rq_if.producer)
	);

	rsp_queue #(.LGFLEN(`SPLIT_LGFLEN)) u_rq (.q(u_rq_if.queue));

	// Same pop also frees a read credit
	assign u_rq_if.pop            = i_s_rready && !u_rq_if.empty;
	assign o_s_rvalid             = !u_rq_if.empty;
	assign {o_s_rdata, o_s_rresp} = u_rq_if.pop_data;

endmodule

// ==== src/read_splitter.sv ====
/* Read path splitter */

`timescale 1ns/1ps
`include "axil_split_macros.svh"

module read_splitter
	import axil_pkg::*;
	import split_pkg::*;
(
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,
	input  logic                          i_arvalid,
	output logic                          o_arready,
	input  logic [`SPLIT_AW-1:0]          i_araddr,
	input  logic [PROT_W-1:0]             i_arprot,
	output logic [`SPLIT_NS-1:0]          o_m_arvalid,
	output logic [PROT_W-1:0]             o_m_arprot,
	input  logic [`SPLIT_NS*`SPLIT_DW-1:0] i_m_rdata,
	input  logic [`SPLIT_NS*2-1:0]        i_m_rresp,
	rsp_queue_if.producer                 rq
);

	localparam int NS = `SPLIT_NS;
	localparam int DW = `SPLIT_DW;
	localparam int CW = $clog2(Q_DEPTH) + 1;

	logic [IDX_W-1:0]  ar_idx;
	logic              ar_xfer;

	// Stage 1, strobe out
	logic [NS-1:0]     r_sel;
	logic [IDX_W-1:0]  r_idx;
	logic [PROT_W-1:0] r_prot;
	logic              r_wait;

	// Stage 2, peripheral data valid
	logic [IDX_W-1:0]  d_idx;
	logic              d_vld;

	// Stage 3, push
	logic              p_push;
	logic [DW-1:0]     p_rdata;
	logic [1:0]        p_resp;

	logic [CW-1:0]     rd_count;
	logic              rd_full;

	assign ar_idx  = i_araddr[`SPLIT_AW-1:ADDR_LSBS];
	assign ar_xfer = i_arvalid && o_arready;

	////////////////////////////////////////////////////////////////////////////
	// Strobe and valid pipeline
	////////////////////////////////////////////////////////////////////////////

	// One-cycle strobe after AR, none for an unmapped index
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_sel  <= '0;
			r_wait <= 1'b0;
			d_vld  <= 1'b0;
			p_push <= 1'b0;
		end
		else
		begin
			if (ar_xfer && (ar_idx < IDX_W'(NS)))
				r_sel <= NS'(1) << ar_idx;
			else
				r_sel <= '0;
			r_wait <= ar_xfer;
			d_vld  <= r_wait;
			p_push <= d_vld;
		end
	end

	// Index rides alongside the valid bits
	always_ff @(posedge S_AXI_ACLK)
	begin
		r_idx  <= ar_idx;
		r_prot <= i_arprot;
		d_idx  <= r_idx;
	end

	assign o_m_arvalid = r_sel;
	assign o_m_arprot  = r_prot;

	// Data select, zero data with DECERR past the last peripheral
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (d_idx >= IDX_W'(NS))
		begin
			p_rdata <= '0;
			p_resp  <= RESP_DECERR;
		end
		else
		begin
			p_rdata <= i_m_rdata[DW*d_idx +: DW];
			p_resp  <= i_m_rresp[2*d_idx +: 2];
		end
	end

	assign rq.push      = p_push;
	assign rq.push_data = {p_rdata, p_resp};

	////////////////////////////////////////////////////////////////////////////
	// Credits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_count <= '0;
		else if (ar_xfer && !rq.pop)
			rd_count <= rd_count + 1'b1;
		else if (!ar_xfer && rq.pop)
			rd_count <= rd_count - 1'b1;
	end

	assign rd_full   = (rd_count == CW'(Q_DEPTH));
	// ARREADY high out of reset, low at the credit limit
	assign o_arready = !rd_full;

	a_credit_limit: assert property (
		@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rd_count <= CW'(Q_DEPTH)
	);

endmodule

// ==== src/write_splitter.sv ====
/* Write path splitter */

`timescale 1ns/1ps
`include "axil_split_macros.svh"

module write_splitter
	import axil_pkg::*;
	import split_pkg::*;
(
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_awvalid,
	output logic                      o_awready,
	input  logic [`SPLIT_AW-1:0]      i_awaddr,
	input  logic [PROT_W-1:0]         i_awprot,
	input  logic                      i_wvalid,
	output logic                      o_wready,
	output logic [`SPLIT_NS-1:0]      o_m_awvalid,
	output logic [PROT_W-1:0]         o_m_awprot,
	input  logic [`SPLIT_NS*2-1:0]    i_m_bresp,
	rsp_queue_if.producer             rq
);

	localparam int NS = `SPLIT_NS;
	localparam int CW = $clog2(Q_DEPTH) + 1;

	// Skid output side
	logic              skid_valid;
	logic              skid_ready;
	logic [IDX_W-1:0]  skid_idx;
	logic [PROT_W-1:0] skid_prot;
	logic              skid_take;

	// Held address phase
	logic              wready;
	logic [NS-1:0]     w_sel;
	logic [IDX_W-1:0]  w_idx;
	logic [PROT_W-1:0] w_prot;
	logic              w_xfer;

	// Response pipeline
	logic              b_pend;
	logic [IDX_W-1:0]  b_idx;
	logic              b_push;
	logic [1:0]        b_resp;

	// Credits
	logic [CW-1:0]     wr_count;
	logic              wr_full;

	////////////////////////////////////////////////////////////////////////////
	// Address acceptance
	////////////////////////////////////////////////////////////////////////////

	skid_buffer #(
		.DW(IDX_W + PROT_W)
	) u_awskid (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (i_awvalid),
		.o_ready      (o_awready),
		.i_data       ({i_awprot, i_awaddr[`SPLIT_AW-1:ADDR_LSBS]}),
		.o_valid      (skid_valid),
		.i_ready      (skid_ready),
		.o_data       ({skid_prot, skid_idx})
	);

	// Next AW may enter as the current W leaves, if credits remain
	assign skid_ready = (!wready || i_wvalid) && !wr_full;
	assign skid_take  = skid_valid && skid_ready;
	assign w_xfer     = i_wvalid && wready;

	// Select held until the W beat, empty select for a bad index
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wready <= 1'b0;
			w_sel  <= '0;
		end
		else if (skid_take)
		begin
			wready <= 1'b1;
			w_sel  <= (skid_idx < IDX_W'(NS)) ? (NS'(1) << skid_idx) : '0;
		end
		else if (i_wvalid)
		begin
			wready <= 1'b0;
			w_sel  <= '0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (skid_take)
		begin
			w_idx  <= skid_idx;
			w_prot <= skid_prot;
		end
	end

	assign o_wready    = wready;
	// Strobe lands in the W transfer cycle
	assign o_m_awvalid = i_wvalid ? w_sel : '0;
	assign o_m_awprot  = w_prot;

	////////////////////////////////////////////////////////////////////////////
	// Response capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			b_pend <= 1'b0;
			b_push <= 1'b0;
		end
		else
		begin
			b_pend <= w_xfer;
			b_push <= b_pend;
		end
	end

	// Peripheral answers one cycle after its strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		b_idx <= w_idx;
		if (b_idx >= IDX_W'(NS))
			b_resp <= RESP_DECERR;
		else
			b_resp <= i_m_bresp[2*b_idx +: 2];
	end

	assign rq.push      = b_push;
	assign rq.push_data = b_resp;

	// Outstanding count, from AW take until the B pop
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_count <= '0;
		else if (skid_take && !rq.pop)
			wr_count <= wr_count + 1'b1;
		else if (!skid_take && rq.pop)
			wr_count <= wr_count - 1'b1;
	end

	assign wr_full = (wr_count == CW'(Q_DEPTH));

	a_awvalid_onehot: assert property (
		@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(o_m_awvalid)
	);

endmodule

// ==== src/rsp_queue.sv ====
/* In-order response FIFO */

`timescale 1ns/1ps

module rsp_queue
	import split_pkg::*;
#(
	parameter int LGFLEN = $clog2(Q_DEPTH)
) (
	rsp_queue_if.queue q
);

	localparam int DEPTH = 1 << LGFLEN;
	localparam int W     = $bits(q.pop_data);

	logic [W-1:0]      mem [DEPTH];
	logic [LGFLEN-1:0] wr_ptr;
	logic [LGFLEN-1:0] rd_ptr;
	logic [LGFLEN-1:0] rd_next;
	logic [LGFLEN:0]   fill;
	logic              rd_en;

	// Pop is ignored on an empty queue
	assign rd_en   = q.pop && (fill != '0);
	assign rd_next = rd_ptr + 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Storage and pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge q.S_AXI_ACLK)
	begin
		if (q.push)
			mem[wr_ptr] <= q.push_data;
	end

	always_ff @(posedge q.S_AXI_ACLK)
	begin
		if (!q.S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (q.push)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_next;
			// Net change of fill
			case ({q.push, rd_en})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Registered head word
	////////////////////////////////////////////////////////////////////////////

	// Head is loaded from the push when the queue is or becomes empty,
	// otherwise from the next slot on each pop
	always_ff @(posedge q.S_AXI_ACLK)
	begin
		if (q.push && ((fill == '0) || ((fill == 1) && rd_en)))
			q.pop_data <= q.push_data;
		else if (rd_en)
			q.pop_data <= mem[rd_next];
	end

	// Not empty one cycle after the first push
	assign q.empty = (fill == '0);

	// Splitter credits must keep pushes off a full queue
	a_no_overflow: assert property (
		@(posedge q.S_AXI_ACLK) disable iff (!q.S_AXI_ARESETN)
		q.push && (fill == DEPTH) |-> q.pop
	);

endmodule

// ==== src/skid_buffer.sv ====
/* Write address skid buffer */

`timescale 1ns/1ps

module skid_buffer #(
	parameter int DW = 8
) (
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	input  logic          i_valid,
	output logic          o_ready,
	input  logic [DW-1:0] i_data,
	output logic          o_valid,
	input  logic          i_ready,
	output logic [DW-1:0] o_data
);

	// Overflow entry
	logic          r_valid;
	logic [DW-1:0] r_data;

	// Fill when a beat arrives and downstream stalls, drain on ready
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Payload only moves while the entry is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Ready comes straight from a flop
	assign o_ready = !r_valid;

	// Pass through when empty, zero latency
	assign o_valid = r_valid || i_valid;
	assign o_data  = r_valid ? r_data : i_data;

	// A held entry stays put until downstream takes it
	a_hold_entry: assert property (
		@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		r_valid && !i_ready |=> r_valid && $stable(r_data)
	);

endmodule

// ==== src/rsp_queue_if.sv ====
/* Response queue interface */

`timescale 1ns/1ps

interface rsp_queue_if #(
	parameter int W = 2
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN
);

	// Write side, driven by a splitter
	logic         push;
	logic [W-1:0] push_data;

	// Read side, pop is formed once at the top level
	logic         pop;
	logic [W-1:0] pop_data;
	logic         empty;

	// Splitter pushes and sees pops for its credit count
	modport producer (
		output push,
		output push_data,
		input  pop
	);

	modport queue (
		input  S_AXI_ACLK,
		input  S_AXI_ARESETN,
		input  push,
		input  push_data,
		input  pop,
		output pop_data,
		output empty
	);

	// Upstream response channel
	modport consumer (
		output pop,
		input  pop_data,
		input  empty
	);

endinterface

// ==== src/split_pkg.sv ====
/* Splitter geometry */

`include "axil_split_macros.svh"

package split_pkg;

	// Byte offset bits below the word index
	localparam int ADDR_LSBS = $clog2(`SPLIT_DW) - 3;

	// Word index selects the peripheral
	localparam int IDX_W = `SPLIT_AW - ADDR_LSBS;

	// One strobe bit per data byte
	localparam int STRB_W = `SPLIT_DW / 8;

	// Entries per response queue, also the credit limit per path
	localparam int Q_DEPTH = 1 << `SPLIT_LGFLEN;

endpackage

// ==== src/axil_pkg.sv ====
/* AXI4-Lite protocol constants */

package axil_pkg;

	// Response codes as seen on BRESP and RRESP
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	// Returned for an index with no peripheral behind it
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// AxPROT width
	localparam int PROT_W = 3;

endpackage

// ==== src/axil_split_macros.svh ====
/* Splitter size macros */

`ifndef AXIL_SPLIT_MACROS_SVH
`define AXIL_SPLIT_MACROS_SVH

// Number of single-register peripherals
`define SPLIT_NS 12

// Bus data width in bits
`define SPLIT_DW 32

// Address width, 4-bit word index over a 2-bit byte offset
`define SPLIT_AW 6

// Log2 of the response queue depth
`define SPLIT_LGFLEN 3

`endif
